//--- hdl/maze_pkg.sv
// Shared types and constants for the maze generator
// Imported by every RTL block of the design
package maze_pkg;

    localparam int grid_w      = 10;
    localparam int grid_h      = 15;
    localparam int num_cells   = grid_w * grid_h;
    localparam int num_h_walls = grid_w * (grid_h + 1);
    localparam int num_v_walls = (grid_w + 1) * grid_h;
    localparam int fill_len    = num_v_walls;
    localparam int walk_steps  = 2 * (num_cells - 1);

    // Bus word map
    localparam int reg_ctrl     = 0;
    localparam int reg_status   = 1;
    localparam int reg_seed     = 2;
    localparam int reg_steps    = 3;
    localparam int h_wall_base  = 16;
    localparam int v_wall_base  = 24;
    localparam int h_wall_words = (num_h_walls + 31) / 32;
    localparam int v_wall_words = (num_v_walls + 31) / 32;

    typedef logic [3:0]  coord_t;
    typedef logic [7:0]  cell_idx_t;
    typedef logic [7:0]  wall_idx_t;
    typedef logic [8:0]  step_cnt_t;
    typedef logic [7:0]  seed_t;
    typedef logic [5:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;
    typedef logic [1:0]  dir_t;
    typedef logic [3:0]  dir_mask_t;

    localparam dir_t dir_up    = 2'd0;
    localparam dir_t dir_right = 2'd1;
    localparam dir_t dir_down  = 2'd2;
    localparam dir_t dir_left  = 2'd3;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } cell_pos_t;

    typedef struct packed {
        logic      valid;
        logic      horiz;  // 1 selects the horizontal wall vector
        wall_idx_t idx;
    } wall_cmd_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        st_idle,
        st_fill,
        st_walk,
        st_done
    } ctrl_state_t;

endpackage

//--- hdl/maze_ctrl_fsm.sv
// Run sequencer: idle, fill, walk and done
// Chooses forward, backtrack or finish on each walk cycle and issues block commands
`timescale 1ns/1ps

module maze_ctrl_fsm
    import maze_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        fill_last,
    input  dir_mask_t   valid_dirs,
    input  cell_pos_t   next_pos,
    input  dir_t        dir,
    input  logic        empty,
    input  cell_pos_t   top,
    output logic        fill_en,
    output logic        step_en,
    output logic        clear,
    output logic        seed_load,
    output logic        advance,
    output logic        mark,
    output logic        push,
    output logic        pop,
    output wall_cmd_t   wall_cmd,
    output cell_pos_t   cur_pos,
    output logic        busy,
    output logic        done
);

    ctrl_state_t state;
    logic        go;
    logic        fwd;
    logic        back;
    wall_idx_t   h_row;   // y * 10
    wall_idx_t   v_row;   // y * 11

    assign go   = start && (state == st_idle || state == st_done);
    assign fwd  = (state == st_walk) && (valid_dirs != '0);
    assign back = (state == st_walk) && (valid_dirs == '0) && !empty;

    assign fill_en   = (state == st_fill);
    assign clear     = go;
    assign seed_load = go;
    assign advance   = fwd;
    assign push      = fwd;
    assign pop       = back;
    assign mark      = fwd || back;  // Dead ends get marked as they are left
    assign step_en   = fwd || back;
    assign busy      = (state == st_fill) || (state == st_walk);
    assign done      = (state == st_done);

    assign h_row = wall_idx_t'(cur_pos.y) * wall_idx_t'(grid_w);
    assign v_row = wall_idx_t'(cur_pos.y) * wall_idx_t'(grid_w + 1);

    always_comb
    begin
        wall_cmd.valid = fwd;
        wall_cmd.horiz = ~dir[0];
        case (dir)
            dir_up:    wall_cmd.idx = h_row + wall_idx_t'(cur_pos.x);
            dir_down:  wall_cmd.idx = h_row + wall_idx_t'(grid_w) + wall_idx_t'(cur_pos.x);
            dir_left:  wall_cmd.idx = v_row + wall_idx_t'(cur_pos.x);
            default:   wall_cmd.idx = v_row + wall_idx_t'(cur_pos.x) + wall_idx_t'(1);
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= st_idle;
            cur_pos <= '0;
        end
        else
        begin
            case (state)
                st_idle, st_done: if (start) state <= st_fill;
                st_fill:          if (fill_last) state <= st_walk;
                default:          if (!fwd && !back) state <= st_done;  // Back at origin
            endcase

            if (go)
                cur_pos <= '0;
            else if (fwd)
                cur_pos <= next_pos;
            else if (back)
                cur_pos <= top;
        end
    end

endmodule

//--- hdl/maze_cycle_counter.sv
// Fill index and walk step counters, both cleared when a run starts
`timescale 1ns/1ps

module maze_cycle_counter
    import maze_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear,
    input  logic      fill_en,
    input  logic      step_en,
    output wall_idx_t fill_idx,
    output logic      fill_last,
    output step_cnt_t steps
);

    assign fill_last = (fill_idx == wall_idx_t'(fill_len - 1));

    always_ff @(posedge clk)
    begin
        if (rst || clear)
        begin
            fill_idx <= '0;
            steps    <= '0;
        end
        else
        begin
            if (fill_en)
                fill_idx <= fill_idx + wall_idx_t'(1);
            if (step_en)
                steps <= steps + step_cnt_t'(1);  // Forward and backtrack alike
        end
    end

endmodule

//--- hdl/maze_cell_store.sv
// Wall vectors and visited flags of the grid
// Filled one index per cycle, then edited by wall breaks and cell marks
`timescale 1ns/1ps

module maze_cell_store
    import maze_pkg::*;
(
    input  logic                   clk,
    input  logic                   fill_en,
    input  wall_idx_t              fill_idx,
    input  wall_cmd_t              wall_cmd,
    input  logic                   mark,
    input  cell_pos_t              cur_pos,
    output dir_mask_t              nb_visited,
    output logic [num_h_walls-1:0] h_walls,
    output logic [num_v_walls-1:0] v_walls
);

    logic [num_cells-1:0] visited;
    cell_idx_t            pos_idx;

    assign pos_idx = cell_idx_t'(cur_pos.y) * cell_idx_t'(grid_w) + cell_idx_t'(cur_pos.x);

    // Off-grid neighbours look visited so they are never chosen
    always_comb
    begin
        nb_visited[dir_up] = (cur_pos.y == '0) ? 1'b1
                           : visited[pos_idx - cell_idx_t'(grid_w)];
        nb_visited[dir_right] = (cur_pos.x == coord_t'(grid_w - 1)) ? 1'b1
                              : visited[pos_idx + cell_idx_t'(1)];
        nb_visited[dir_down] = (cur_pos.y == coord_t'(grid_h - 1)) ? 1'b1
                             : visited[pos_idx + cell_idx_t'(grid_w)];
        nb_visited[dir_left] = (cur_pos.x == '0) ? 1'b1
                             : visited[pos_idx - cell_idx_t'(1)];
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            if (fill_idx < wall_idx_t'(num_h_walls))
                h_walls[fill_idx] <= 1'b1;
            v_walls[fill_idx] <= 1'b1;  // Fill runs exactly over the v range
        end
        else if (wall_cmd.valid)
        begin
            if (wall_cmd.horiz)
                h_walls[wall_cmd.idx] <= 1'b0;
            else
                v_walls[wall_cmd.idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            if (fill_idx < wall_idx_t'(num_cells))
                visited[fill_idx] <= 1'b0;
        end
        else if (mark)
        begin
            visited[pos_idx] <= 1'b1;
        end
    end

endmodule

//--- hdl/maze_pos_stack.sv
// Position stack for backtracking during the walk
// One entry per cell is enough since every push enters a new cell
`timescale 1ns/1ps

module maze_pos_stack
    import maze_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear,
    input  logic      push,
    input  logic      pop,
    input  cell_pos_t push_pos,
    output cell_pos_t top,
    output logic      empty
);

    cell_pos_t mem [num_cells];
    cell_idx_t ptr;  // Next free slot

    assign empty = (ptr == '0);
    assign top   = empty ? '0 : mem[ptr - cell_idx_t'(1)];

    always_ff @(posedge clk)
    begin
        if (rst || clear)
            ptr <= '0;
        else if (push)
            ptr <= ptr + cell_idx_t'(1);
        else if (pop)
            ptr <= ptr - cell_idx_t'(1);
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[ptr] <= push_pos;
    end

endmodule

//--- hdl/maze_dir_picker.sv
// Random direction choice among unvisited neighbours
// xorshift source is loaded from the seed at start and steps on each forward move
`timescale 1ns/1ps

module maze_dir_picker
    import maze_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      seed_load,
    input  logic      advance,
    input  seed_t     seed,
    input  cell_pos_t cur_pos,
    input  dir_mask_t nb_visited,
    output dir_mask_t valid_dirs,
    output dir_t      dir,
    output cell_pos_t next_pos
);

    seed_t rnd;
    seed_t rnd_nxt;
    dir_t  d0;
    dir_t  d1;
    dir_t  d2;

    always_comb
    begin
        rnd_nxt = rnd ^ (rnd << 7);
        rnd_nxt = rnd_nxt ^ (rnd_nxt >> 5);
        rnd_nxt = rnd_nxt ^ (rnd_nxt << 3);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            rnd <= seed_t'(1);
        else if (seed_load)
            rnd <= seed;  // Never zero, the bus block replaces it
        else if (advance)
            rnd <= rnd_nxt;
    end

    assign valid_dirs = ~nb_visited;

    // Rotate from the low random bits to the first open direction
    assign d0  = rnd[1:0];
    assign d1  = d0 + dir_t'(1);
    assign d2  = d0 + dir_t'(2);
    assign dir = valid_dirs[d0] ? d0 : valid_dirs[d1] ? d1 : valid_dirs[d2] ? d2 : d0 - dir_t'(1);

    always_comb
    begin
        next_pos = cur_pos;
        case (dir)
            dir_up:    next_pos.y = cur_pos.y - coord_t'(1);
            dir_right: next_pos.x = cur_pos.x + coord_t'(1);
            dir_down:  next_pos.y = cur_pos.y + coord_t'(1);
            default:   next_pos.x = cur_pos.x - coord_t'(1);
        endcase
    end

endmodule

//--- hdl/maze_wb_regs.sv
// Wishbone classic slave: control, status, seed, step count and wall readout
// Every access is acknowledged one cycle after cyc and stb are seen
`timescale 1ns/1ps

module maze_wb_regs
    import maze_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  wb_req_t                wb_req,
    output wb_rsp_t                wb_rsp,
    output logic                   start,
    output seed_t                  seed,
    input  logic                   busy,
    input  logic                   done,
    input  step_cnt_t              steps,
    input  logic [num_h_walls-1:0] h_walls,
    input  logic [num_v_walls-1:0] v_walls
);

    logic                        ack;
    logic                        access;
    wb_dat_t                     rd_dat;
    wb_dat_t                     rd_mux;
    wb_adr_t                     h_off;
    wb_adr_t                     v_off;
    logic [32*v_wall_words-1:0]  v_pad;

    assign access = wb_req.cyc && wb_req.stb && !ack;
    assign v_pad  = {{(32 * v_wall_words - num_v_walls){1'b0}}, v_walls};
    assign h_off  = wb_req.adr - wb_adr_t'(h_wall_base);
    assign v_off  = wb_req.adr - wb_adr_t'(v_wall_base);

    always_comb
    begin
        rd_mux = '0;
        if (wb_req.adr == wb_adr_t'(reg_status))
            rd_mux = {30'b0, done, busy};
        else if (wb_req.adr == wb_adr_t'(reg_seed))
            rd_mux = wb_dat_t'(seed);
        else if (wb_req.adr == wb_adr_t'(reg_steps))
            rd_mux = wb_dat_t'(steps);
        else if (h_off < wb_adr_t'(h_wall_words))
            rd_mux = h_walls[32*h_off[2:0] +: 32];
        else if (v_off < wb_adr_t'(v_wall_words))
            rd_mux = v_pad[32*v_off[2:0] +: 32];  // Top word padded with zeros
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ack   <= 1'b0;
            start <= 1'b0;
            seed  <= seed_t'(1);
        end
        else
        begin
            ack   <= access;
            start <= access && wb_req.we && wb_req.adr == wb_adr_t'(reg_ctrl) && wb_req.dat[0];
            if (access && wb_req.we && wb_req.adr == wb_adr_t'(reg_seed))
                seed <= (wb_req.dat[7:0] == '0) ? seed_t'(1) : wb_req.dat[7:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (access)
            rd_dat <= wb_req.we ? '0 : rd_mux;
    end

    assign wb_rsp = '{ack: ack, dat: rd_dat};

endmodule

//--- hdl/maze_top.sv
// Maze generator top level, a 10 by 15 grid controlled over Wishbone classic
`timescale 1ns/1ps

module maze_top
    import maze_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    logic                   start;
    seed_t                  seed;
    logic                   busy;
    logic                   done;
    step_cnt_t              steps;
    logic [num_h_walls-1:0] h_walls;
    logic [num_v_walls-1:0] v_walls;
    logic                   fill_en;
    logic                   step_en;
    logic                   clear;
    logic                   seed_load;
    logic                   advance;
    logic                   mark;
    logic                   push;
    logic                   pop;
    logic                   fill_last;
    logic                   empty;
    wall_idx_t              fill_idx;
    wall_cmd_t              wall_cmd;
    cell_pos_t              cur_pos;
    cell_pos_t              next_pos;
    cell_pos_t              top;
    dir_mask_t              nb_visited;
    dir_mask_t              valid_dirs;
    dir_t                   dir;

    maze_wb_regs u_regs (
        .clk, .rst, .wb_req, .wb_rsp, .start, .seed,
        .busy, .done, .steps, .h_walls, .v_walls
    );

    maze_ctrl_fsm u_fsm (
        .clk, .rst, .start, .fill_last, .valid_dirs, .next_pos, .dir, .empty, .top,
        .fill_en, .step_en, .clear, .seed_load, .advance, .mark, .push, .pop,
        .wall_cmd, .cur_pos, .busy, .done
    );

    maze_cycle_counter u_cnt (
        .clk, .rst, .clear, .fill_en, .step_en, .fill_idx, .fill_last, .steps
    );

    maze_cell_store u_store (
        .clk, .fill_en, .fill_idx, .wall_cmd, .mark, .cur_pos,
        .nb_visited, .h_walls, .v_walls
    );

    maze_pos_stack u_stack (
        .clk, .rst, .clear, .push, .pop, .push_pos(cur_pos), .top, .empty
    );

    maze_dir_picker u_picker (
        .clk, .rst, .seed_load, .advance, .seed, .cur_pos, .nb_visited,
        .valid_dirs, .dir, .next_pos
    );

endmodule

//--- sim/tb_clock.sv
// Free-running testbench clock, 100 ns period
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam time half_period = 50;

    initial
    begin
        clk = 1'b0;
        forever
            #half_period clk = ~clk;
    end

endmodule

//--- sim/maze_tb.sv
// Testbench for the maze generator that drives the Wishbone port and checks each maze read back
// Prints a closing error count line followed by the verdict
`timescale 1ns/1ps

module maze_tb
    import maze_pkg::*;
();

    localparam int done_limit = 470;
    localparam int run_cycles = fill_len + walk_steps + 2;
    localparam int num_runs   = 5;
    localparam int bus_margin = 335;  // Seed, start, polling and readback
    localparam int max_cycles = num_runs * (run_cycles + bus_margin);
    localparam int num_words  = h_wall_words + v_wall_words;

    typedef struct packed {
        logic       border_ok;
        logic [8:0] removed;
        logic [8:0] reached;
    } maze_summary_t;

    logic        clk;
    logic        rst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          cycle_cnt = 0;
    int          mismatch_cnt = 0;
    int          fail_cnt = 0;
    logic [31:0] rng_state = 32'd82;
    seed_t       seeds [4];
    wb_dat_t     maze_words [num_runs][num_words];
    wb_dat_t     rd;
    int          diff_cnt;
    string       chk_name_q [$];
    wb_dat_t     chk_exp_q [$];
    wb_dat_t     chk_act_q [$];
    event        chk_ev;

    tb_clock u_clk (.clk);

    maze_top u_dut (.clk, .rst, .wb_req, .wb_rsp);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        return r ^ (r << 5);
    endfunction

    // Border state, removed wall count and flood fill reach from (0,0)
    function automatic maze_summary_t maze_check(input logic [num_h_walls-1:0] h,
                                                 input logic [num_v_walls-1:0] v);
        maze_summary_t res;
        logic          seen [num_cells];
        int            order [num_cells];
        int            head;
        int            tail;
        int            c;
        int            n;
        int            x;
        int            y;
        logic          open;
        res = '0;
        res.border_ok = 1'b1;
        for (int i = 0; i < grid_w; i++)
            if (!h[i] || !h[grid_h * grid_w + i])
                res.border_ok = 1'b0;
        for (int i = 0; i < grid_h; i++)
            if (!v[i * (grid_w + 1)] || !v[i * (grid_w + 1) + grid_w])
                res.border_ok = 1'b0;
        for (int i = 0; i < num_h_walls; i++)
            if (!h[i])
                res.removed = res.removed + 1'b1;
        for (int i = 0; i < num_v_walls; i++)
            if (!v[i])
                res.removed = res.removed + 1'b1;
        foreach (seen[i])
            seen[i] = 1'b0;
        seen[0] = 1'b1;
        order[0] = 0;
        head = 0;
        tail = 1;
        while (head < tail)
        begin
            c = order[head];
            head++;
            x = c % grid_w;
            y = c / grid_w;
            for (int d = 0; d < 4; d++)
            begin
                case (d)  // up, right, down, left
                    0:
                    begin
                        open = (y > 0) && !h[y * grid_w + x];
                        n = c - grid_w;
                    end
                    1:
                    begin
                        open = (x < grid_w - 1) && !v[y * (grid_w + 1) + x + 1];
                        n = c + 1;
                    end
                    2:
                    begin
                        open = (y < grid_h - 1) && !h[(y + 1) * grid_w + x];
                        n = c + grid_w;
                    end
                    default:
                    begin
                        open = (x > 0) && !v[y * (grid_w + 1) + x];
                        n = c - 1;
                    end
                endcase
                if (open && !seen[n])
                begin
                    seen[n] = 1'b1;
                    order[tail] = n;
                    tail++;
                end
            end
        end
        res.reached = 9'(tail);
        return res;
    endfunction

    task automatic expect_eq(input string name, input wb_dat_t exp_val, input wb_dat_t act_val);
        chk_name_q.push_back(name);
        chk_exp_q.push_back(exp_val);
        chk_act_q.push_back(act_val);
        -> chk_ev;
    endtask

    // Compare process draining queued checks as they arrive
    initial
    begin
        forever
        begin
            @(chk_ev);
            while (chk_name_q.size() != 0)
            begin
                assert (chk_act_q[0] === chk_exp_q[0])
                else
                begin
                    mismatch_cnt++;
                    $display("mismatch %s: expected 0x%0h, actual 0x%0h",
                             chk_name_q[0], chk_exp_q[0], chk_act_q[0]);
                end
                chk_exp_q.delete(0);
                chk_act_q.delete(0);
                chk_name_q.delete(0);
            end
        end
    end

    task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                              output wb_dat_t rdat);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!wb_rsp.ack && waited < 4);
        assert (wb_rsp.ack)
        else
        begin
            fail_cnt++;
            $display("bus access to address %0d got no ack within 4 cycles", adr);
        end
        rdat = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t wdat);
        wb_dat_t unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t rdat);
        bus_access(1'b0, adr, '0, rdat);
    endtask

    task automatic draw_seed(input int n);
        logic fresh;
        fresh = 1'b0;
        while (!fresh)
        begin
            rng_state = xorshift32(rng_state);
            seeds[n] = rng_state[7:0];
            fresh = (seeds[n] != '0);
            for (int i = 0; i < n; i++)
                if (seeds[i] == seeds[n])
                    fresh = 1'b0;
        end
    endtask

    // Busy must hold until done, and done must come in time
    task automatic wait_for_done(input int t0);
        wb_dat_t st;
        int      elapsed;
        st = '0;
        elapsed = 0;
        while (!st[1] && elapsed <= done_limit)
        begin
            wb_read(wb_adr_t'(reg_status), st);
            elapsed = cycle_cnt - t0;
            if (!st[1])
            begin
                assert (st[0])
                else
                begin
                    fail_cnt++;
                    $display("status not busy %0d cycles into a run", elapsed);
                end
            end
        end
        assert (elapsed <= done_limit)
        else
        begin
            fail_cnt++;
            $display("done seen %0d cycles after the start ack, limit is %0d",
                     elapsed, done_limit);
        end
        expect_eq("status after done", 32'h2, st);
    endtask

    task automatic run_maze(input int run, input seed_t seed, input logic restart);
        wb_dat_t d;
        int      t0;
        wb_write(wb_adr_t'(reg_seed), wb_dat_t'(seed));
        wb_write(wb_adr_t'(reg_ctrl), 32'h1);
        t0 = cycle_cnt;
        if (restart)
        begin
            repeat (250) @(negedge clk);  // Well into the walk
            wb_write(wb_adr_t'(reg_ctrl), 32'h1);
        end
        wait_for_done(t0);
        wb_read(wb_adr_t'(reg_steps), d);
        expect_eq($sformatf("steps seed %0d", seed), wb_dat_t'(walk_steps), d);
        for (int i = 0; i < h_wall_words; i++)
            wb_read(wb_adr_t'(h_wall_base + i), maze_words[run][i]);
        for (int i = 0; i < v_wall_words; i++)
            wb_read(wb_adr_t'(v_wall_base + i), maze_words[run][h_wall_words + i]);
    endtask

    task automatic check_maze(input int run, input seed_t seed);
        logic [32*h_wall_words-1:0] h;
        logic [32*v_wall_words-1:0] v;
        maze_summary_t              sum;
        for (int i = 0; i < h_wall_words; i++)
            h[32*i +: 32] = maze_words[run][i];
        for (int i = 0; i < v_wall_words; i++)
            v[32*i +: 32] = maze_words[run][h_wall_words + i];
        sum = maze_check(h[num_h_walls-1:0], v[num_v_walls-1:0]);
        expect_eq($sformatf("border seed %0d", seed), 32'h1, wb_dat_t'(sum.border_ok));
        expect_eq($sformatf("removed walls seed %0d", seed), 32'd149, wb_dat_t'(sum.removed));
        expect_eq($sformatf("reachable cells seed %0d", seed), 32'd150, wb_dat_t'(sum.reached));
        expect_eq($sformatf("v word padding seed %0d", seed), 32'h0,
                  wb_dat_t'(v[32*v_wall_words-1:num_v_walls]));
    endtask

    task automatic print_error_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles)
        begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            print_error_counts();
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial
    begin
        wb_req = '0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        wb_read(wb_adr_t'(reg_status), rd);
        expect_eq("status after reset", 32'h0, rd);
        wb_read(wb_adr_t'(reg_steps), rd);
        expect_eq("steps after reset", 32'h0, rd);
        wb_read(wb_adr_t'(reg_seed), rd);
        expect_eq("seed after reset", 32'h1, rd);
        foreach (seeds[i])
            draw_seed(i);

        // Unmapped words including gaps around the wall blocks
        wb_read(wb_adr_t'(4), rd);
        expect_eq("unmapped 4", 32'h0, rd);
        wb_read(wb_adr_t'(21), rd);
        expect_eq("unmapped 21", 32'h0, rd);
        wb_read(wb_adr_t'(30), rd);
        expect_eq("unmapped 30", 32'h0, rd);
        wb_read(wb_adr_t'(63), rd);
        expect_eq("unmapped 63", 32'h0, rd);
        wb_write(wb_adr_t'(reg_seed), 32'h0);
        wb_read(wb_adr_t'(reg_seed), rd);
        expect_eq("seed 0 readback", 32'h1, rd);

        run_maze(0, seeds[0], 1'b1);
        for (int r = 1; r < 4; r++)
            run_maze(r, seeds[r], 1'b0);
        run_maze(4, seeds[0], 1'b0);
        for (int r = 0; r < 4; r++)
            check_maze(r, seeds[r]);

        diff_cnt = 0;
        for (int i = 0; i < num_words; i++)
        begin
            expect_eq($sformatf("rerun word %0d", i), maze_words[0][i], maze_words[4][i]);
            if (maze_words[0][i] != maze_words[1][i])
                diff_cnt++;
        end
        expect_eq("two seeds differ", 32'h1, wb_dat_t'(diff_cnt != 0));

        @(posedge clk);
        print_error_counts();
        if (mismatch_cnt == 0 && fail_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- maze_gen.f
hdl/maze_pkg.sv
hdl/maze_ctrl_fsm.sv
hdl/maze_cycle_counter.sv
hdl/maze_cell_store.sv
hdl/maze_pos_stack.sv
hdl/maze_dir_picker.sv
hdl/maze_wb_regs.sv
hdl/maze_top.sv
sim/tb_clock.sv
sim/maze_tb.sv

//--- Bender.yml
package:
  name: maze_gen

sources:
  - target: any(rtl, simulation)
    files:
      - hdl/maze_pkg.sv
      - hdl/maze_ctrl_fsm.sv
      - hdl/maze_cycle_counter.sv
      - hdl/maze_cell_store.sv
      - hdl/maze_pos_stack.sv
      - hdl/maze_dir_picker.sv
      - hdl/maze_wb_regs.sv
      - hdl/maze_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/maze_tb.sv
